/* verilog/muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

    // Operand and result width
    parameter int XLEN = 32;

    // Register file index width
    parameter int REG_IDX_W = 5;

    // Encoding equals funct3 of the OP opcode with funct7 = 0000001
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,  // Low word, signed x signed
        OP_MULH   = 3'b001,  // High word, signed x signed
        OP_MULHSU = 3'b010,  // High word, signed x unsigned
        OP_MULHU  = 3'b011,  // High word, unsigned x unsigned
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

endpackage

`default_nettype wire

/* verilog/muldiv_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Request path from the issue register into the core
interface muldiv_issue_if;

    logic                              req_valid;  // Issue register holds an entry
    muldiv_pkg::muldiv_op_e            req_op;
    logic [muldiv_pkg::REG_IDX_W-1:0]  req_rd;
    logic [muldiv_pkg::XLEN-1:0]       req_a;      // rs1 value
    logic [muldiv_pkg::XLEN-1:0]       req_b;      // rs2 value
    logic                              req_take;   // Core consumes entry on this edge

    modport issue (
        output req_valid,
        output req_op,
        output req_rd,
        output req_a,
        output req_b,
        input  req_take
    );

    modport core (
        input  req_valid,
        input  req_op,
        input  req_rd,
        input  req_a,
        input  req_b,
        output req_take
    );

endinterface

// Finished result from the core, one cycle wide per operation
interface muldiv_result_if;

    logic                              res_valid;
    logic [muldiv_pkg::REG_IDX_W-1:0]  res_rd;
    logic [muldiv_pkg::XLEN-1:0]       res_data;

    modport core (output res_valid, output res_rd, output res_data);
    modport wb   (input  res_valid, input  res_rd, input  res_data);

endinterface

`default_nettype wire

/* verilog/muldiv_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_issue (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start_i,
    input  wire logic [2:0]                        funct3_i,
    input  wire logic [muldiv_pkg::REG_IDX_W-1:0]  rd_i,
    input  wire logic [muldiv_pkg::XLEN-1:0]       rs1_i,
    input  wire logic [muldiv_pkg::XLEN-1:0]       rs2_i,
    input  wire logic                              flush_i,
    input  wire logic                              stall_i,
    output logic                                   ready_o,
    muldiv_issue_if.issue                          iss
);

    logic                              full_q;
    muldiv_pkg::muldiv_op_e            op_q;
    logic [muldiv_pkg::REG_IDX_W-1:0]  rd_q;
    logic [muldiv_pkg::XLEN-1:0]       a_q;
    logic [muldiv_pkg::XLEN-1:0]       b_q;
    logic                              accept;

    // Slot is free, or the core empties it on this very edge
    assign ready_o = !stall_i && (!full_q || iss.req_take);
    assign accept  = start_i && ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;           // Flush wins over stall and accept
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (iss.req_take) begin
            full_q <= 1'b0;
        end
    end

    // Payload only, occupancy lives in full_q
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= muldiv_pkg::muldiv_op_e'(funct3_i);
            rd_q <= rd_i;
            a_q  <= rs1_i;
            b_q  <= rs2_i;
        end
    end

    assign iss.req_valid = full_q;
    assign iss.req_op    = op_q;
    assign iss.req_rd    = rd_q;
    assign iss.req_a     = a_q;
    assign iss.req_b     = b_q;

endmodule

`default_nettype wire

/* verilog/muldiv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_core #(
    parameter int MUL_LAT = 2,   // EXEC cycles for MUL*, at least 1
    parameter int DIV_LAT = 32   // EXEC cycles for DIV*/REM*, at least 1
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  flush_i,
    input  wire logic  stall_i,
    muldiv_issue_if.core   iss,
    muldiv_result_if.core  res
);

    localparam int MAX_LAT = (DIV_LAT > MUL_LAT) ? DIV_LAT : MUL_LAT;
    localparam int CNT_W   = $clog2(MAX_LAT + 1);
    localparam int XLEN    = muldiv_pkg::XLEN;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } state_e;

    state_e                            state_q;
    logic [CNT_W-1:0]                  cnt_q;
    muldiv_pkg::muldiv_op_e            op_q;
    logic [muldiv_pkg::REG_IDX_W-1:0]  rd_q;
    logic [XLEN-1:0]                   a_q;
    logic [XLEN-1:0]                   b_q;
    logic [XLEN-1:0]                   result_q;
    logic [XLEN-1:0]                   result_d;
    logic                              take;
    logic                              finish;
    logic                              div_zero;
    logic                              div_ovf;
    logic signed [2*XLEN-1:0]          prod_ss;
    logic signed [2*XLEN-1:0]          prod_su;
    logic        [2*XLEN-1:0]          prod_uu;

    assign take   = (state_q == IDLE) && iss.req_valid && !stall_i;
    assign finish = (state_q == EXEC) && (cnt_q == '0) && !stall_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= IDLE;          // In-flight operation is dropped
            cnt_q   <= '0;
        end else if (!stall_i) begin
            case (state_q)
                IDLE: begin
                    if (take) begin
                        state_q <= EXEC;
                        if (iss.req_op >= muldiv_pkg::OP_DIV) begin
                            cnt_q <= CNT_W'(DIV_LAT - 1);
                        end else begin
                            cnt_q <= CNT_W'(MUL_LAT - 1);
                        end
                    end
                end
                EXEC: begin
                    if (cnt_q == '0) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                DONE:    state_q <= IDLE;   // Result handed over this edge
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q <= iss.req_op;
            rd_q <= iss.req_rd;
            a_q  <= iss.req_a;
            b_q  <= iss.req_b;
        end
        if (finish) begin
            result_q <= result_d;
        end
    end

    // Full-width products, sign handling per variant
    assign prod_ss = $signed(a_q) * $signed(b_q);
    assign prod_su = $signed(a_q) * $signed({1'b0, b_q});
    assign prod_uu = {{XLEN{1'b0}}, a_q} * {{XLEN{1'b0}}, b_q};

    assign div_zero = (b_q == '0);
    assign div_ovf  = (a_q == {1'b1, {(XLEN-1){1'b0}}}) && (b_q == '1);  // INT_MIN / -1

    always_comb begin
        result_d = '0;
        case (op_q)
            muldiv_pkg::OP_MUL:    result_d = prod_ss[XLEN-1:0];
            muldiv_pkg::OP_MULH:   result_d = prod_ss[2*XLEN-1:XLEN];
            muldiv_pkg::OP_MULHSU: result_d = prod_su[2*XLEN-1:XLEN];
            muldiv_pkg::OP_MULHU:  result_d = prod_uu[2*XLEN-1:XLEN];
            muldiv_pkg::OP_DIV: begin
                if (div_zero)     result_d = '1;
                else if (div_ovf) result_d = a_q;
                else              result_d = $signed(a_q) / $signed(b_q);
            end
            muldiv_pkg::OP_DIVU: begin
                if (div_zero) result_d = '1;
                else          result_d = a_q / b_q;
            end
            muldiv_pkg::OP_REM: begin
                if (div_zero)     result_d = a_q;     // Dividend passes through
                else if (div_ovf) result_d = '0;
                else              result_d = $signed(a_q) % $signed(b_q);
            end
            muldiv_pkg::OP_REMU: begin
                if (div_zero) result_d = a_q;
                else          result_d = a_q % b_q;
            end
            default: result_d = '0;
        endcase
    end

    assign iss.req_take  = take;
    assign res.res_valid = (state_q == DONE) && !stall_i && !flush_i;
    assign res.res_rd    = rd_q;
    assign res.res_data  = result_q;

endmodule

`default_nettype wire

/* verilog/muldiv_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_writeback (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              stall_i,
    muldiv_result_if.wb                            res,
    output logic                                   wb_valid_o,
    output logic [muldiv_pkg::REG_IDX_W-1:0]       wb_rd_o,
    output logic [muldiv_pkg::XLEN-1:0]            wb_data_o
);

    logic write_en;

    // x0 is hardwired, nothing to write
    assign write_en = res.res_valid && (res.res_rd != '0);

    // Register file write port sees these directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
        end else if (!stall_i) begin
            wb_valid_o <= write_en;
            if (write_en) begin
                wb_rd_o   <= res.res_rd;
                wb_data_o <= res.res_data;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/muldiv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
    parameter int MUL_LAT = 2,
    parameter int DIV_LAT = 32
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start_i,
    input  wire logic [2:0]                        funct3_i,
    input  wire logic [muldiv_pkg::REG_IDX_W-1:0]  rd_i,
    input  wire logic [muldiv_pkg::XLEN-1:0]       rs1_i,
    input  wire logic [muldiv_pkg::XLEN-1:0]       rs2_i,
    input  wire logic                              flush_i,
    input  wire logic                              stall_i,
    output logic                                   ready_o,
    output logic                                   wb_valid_o,
    output logic [muldiv_pkg::REG_IDX_W-1:0]       wb_rd_o,
    output logic [muldiv_pkg::XLEN-1:0]            wb_data_o
);

    muldiv_issue_if  iss_if ();
    muldiv_result_if res_if ();

    muldiv_issue i_issue (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .funct3_i (funct3_i),
        .rd_i     (rd_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .flush_i  (flush_i),
        .stall_i  (stall_i),
        .ready_o  (ready_o),
        .iss      (iss_if.issue)
    );

    muldiv_core #(
        .MUL_LAT (MUL_LAT),
        .DIV_LAT (DIV_LAT)
    ) i_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .stall_i (stall_i),
        .iss     (iss_if.core),
        .res     (res_if.core)
    );

    // No flush here, a registered result always retires
    muldiv_writeback i_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall_i),
        .res        (res_if.wb),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* tests/muldiv_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_checker (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              stall_i,
    input  wire logic                              ready_i,
    input  wire logic                              wb_valid_i,
    input  wire logic [muldiv_pkg::REG_IDX_W-1:0]  wb_rd_i,
    input  wire logic [muldiv_pkg::XLEN-1:0]       wb_data_i
);

    logic [muldiv_pkg::REG_IDX_W-1:0]  exp_rd_q [$];
    logic [muldiv_pkg::XLEN-1:0]       exp_data_q [$];
    logic [muldiv_pkg::REG_IDX_W-1:0]  exp_rd;
    logic [muldiv_pkg::XLEN-1:0]       exp_data;
    logic                              rst_seen = 1'b0;
    int                                data_errs = 0;
    int                                rd_errs = 0;
    int                                ctrl_errs = 0;
    int                                extra_errs = 0;

    task automatic push_expected(input logic [muldiv_pkg::REG_IDX_W-1:0] rd,
                                 input logic [muldiv_pkg::XLEN-1:0] data);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending();
        return exp_rd_q.size();
    endfunction

    // Leftover entries are results that never arrived
    function automatic int error_total();
        return data_errs + rd_errs + ctrl_errs + extra_errs + exp_rd_q.size();
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            ctrl_errs++;
            $display("[ERROR] %0t ns: %s got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    // Cycles from the accepting edge to the rise of wb_valid_o
    task automatic check_latency(input int got, input int expected);
        if (got != expected) begin
            ctrl_errs++;
            $display("[ERROR] %0t ns: wb_valid_o rose %0d cycles after accept, expected %0d",
                     $time, got, expected);
        end
    endtask

    // Port values on the first edge after reset release, and ready_o under stall
    always @(posedge clk) begin
        if (rst_n && !rst_seen) begin
            rst_seen = 1'b1;
            compare_value("ready_o", 32'(ready_i), 32'd1);
            compare_value("wb_valid_o", 32'(wb_valid_i), 32'd0);
            compare_value("wb_rd_o", 32'(wb_rd_i), 32'd0);
            compare_value("wb_data_o", wb_data_i, 32'd0);
        end
        if (rst_n && stall_i) begin
            compare_value("ready_o", 32'(ready_i), 32'd0);  // Low for the whole stall
        end
    end

    // A held pulse counts once, on its first unstalled edge
    always @(posedge clk) begin
        if (rst_n && wb_valid_i && !stall_i) begin
            if (exp_rd_q.size() == 0) begin
                extra_errs++;
                $display("Unexpected writeback at %0t ns: x%0d <= %08h with nothing pending",
                         $time, wb_rd_i, wb_data_i);
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (wb_rd_i !== exp_rd) begin
                    rd_errs++;
                    $display("[ERROR] %0t ns: wb_rd_o got %0d, expected %0d",
                             $time, wb_rd_i, exp_rd);
                end
                if (wb_data_i !== exp_data) begin
                    data_errs++;
                    $display("[ERROR] %0t ns: wb_data_o got %08h, expected %08h",
                             $time, wb_data_i, exp_data);
                end
            end
        end
    end

    task automatic print_summary(input int timeouts, input int others);
        $display(
            "Errors: data %0d, rd %0d, control %0d, extra %0d, missing %0d, timeout %0d, other %0d",
            data_errs, rd_errs, ctrl_errs, extra_errs, exp_rd_q.size(), timeouts, others);
    endtask

endmodule

`default_nettype wire

/* tests/muldiv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

    localparam int MUL_LAT    = 2;
    localparam int DIV_LAT    = 32;
    localparam int RW         = muldiv_pkg::REG_IDX_W;
    localparam int XLEN       = muldiv_pkg::XLEN;
    localparam int DRIVE_DLY  = 10;    // ns after the rising edge
    localparam int MAX_RECS   = 32;
    localparam int WAIT_LIMIT = 1000;  // Cycles per issue or drain wait
    localparam int LAT_LIMIT  = 100;

    logic             clk;
    logic             rst_n;
    logic             start_i;
    logic [2:0]       funct3_i;
    logic [RW-1:0]    rd_i;
    logic [XLEN-1:0]  rs1_i;
    logic [XLEN-1:0]  rs2_i;
    logic             flush_i;
    logic             stall_i = 1'b0;
    logic             ready_o;
    logic             wb_valid_o;
    logic [RW-1:0]    wb_rd_o;
    logic [XLEN-1:0]  wb_data_o;

    logic [31:0]      test_mem [0:6*MAX_RECS-1];  // Six words per record
    logic [31:0]      lfsr = 32'h03ae044a;
    logic             stall_en;
    logic             stall_now;
    int               timeout_errs;
    int               other_errs;

    muldiv_unit #(
        .MUL_LAT (MUL_LAT),
        .DIV_LAT (DIV_LAT)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .funct3_i   (funct3_i),
        .rd_i       (rd_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .flush_i    (flush_i),
        .stall_i    (stall_i),
        .ready_o    (ready_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    muldiv_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall_i),
        .ready_i    (ready_o),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR bit per cycle decides the stall
    always @(posedge clk) begin
        stall_now = stall_en;
        #DRIVE_DLY;
        if (stall_now) begin
            lfsr    = lfsr_step(lfsr);
            stall_i = lfsr[0];
        end else begin
            stall_i = 1'b0;
        end
    end

    // Holds the request until ready_o is seen high on an edge
    task automatic issue_request(input int base, output logic accepted);
        int waited;
        waited   = 0;
        accepted = 1'b0;
        start_i  = 1'b1;
        funct3_i = test_mem[base+1][2:0];
        rd_i     = test_mem[base+2][RW-1:0];
        rs1_i    = test_mem[base+3];
        rs2_i    = test_mem[base+4];
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = ready_o;
            waited++;
            #DRIVE_DLY;
        end
        start_i = 1'b0;
        if (!accepted) begin
            timeout_errs++;
            $display("Timeout at %0t ns: request %0d was never accepted", $time, base / 6);
        end
    endtask

    task automatic wait_drained();
        int   waited;
        logic rdy;
        waited = 0;
        rdy    = 1'b0;
        while ((!rdy || i_checker.pending() != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            rdy = ready_o;
            waited++;
            #DRIVE_DLY;    // Checker has popped by now
        end
        if (!rdy || i_checker.pending() != 0) begin
            timeout_errs++;
            $display("Timeout at %0t ns: unit did not drain, %0d results outstanding",
                     $time, i_checker.pending());
        end
    endtask

    task automatic measure_latency(input int expected);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < LAT_LIMIT) begin
            @(posedge clk);
            seen = wb_valid_o;   // Value from the previous edge
            cycles++;
        end
        #DRIVE_DLY;
        if (!seen) begin
            timeout_errs++;
            $display("Timeout at %0t ns: timed request gave no writeback", $time);
        end else begin
            i_checker.check_latency(cycles - 1, expected);
        end
    endtask

    initial begin
        int   idx;
        int   base;
        logic accepted;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        funct3_i     = '0;
        rd_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        flush_i      = 1'b0;
        stall_en     = 1'b0;
        timeout_errs = 0;
        other_errs   = 0;
        $readmemh("tests/muldiv_testdata.txt", test_mem);
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (idx = 0; idx < MAX_RECS; idx++) begin
            base = idx * 6;
            if ($isunknown(test_mem[base]) || test_mem[base] == 32'hff) begin
                break;
            end
            // Flushed and timed requests start on an idle unit without stall
            stall_en = (test_mem[base] == 32'h0);
            if (!stall_en) begin
                wait_drained();
            end
            issue_request(base, accepted);
            if (accepted && test_mem[base] == 32'h1) begin
                flush_i = 1'b1;      // Edge after the accepting one
                @(posedge clk);
                #DRIVE_DLY;
                flush_i = 1'b0;
            end else if (accepted) begin
                if (rd_i != '0) begin
                    i_checker.push_expected(rd_i, test_mem[base+5]);
                end
                if (test_mem[base] == 32'h2) begin
                    measure_latency((funct3_i[2] ? DIV_LAT : MUL_LAT) + 2);
                end
            end
        end
        if (idx == 0) begin
            other_errs++;
            $display("No stimulus records read from tests/muldiv_testdata.txt");
        end

        stall_en = 1'b0;
        wait_drained();
        repeat (DIV_LAT + 4) @(posedge clk);   // Room for a stray late result
        i_checker.print_summary(timeout_errs, other_errs);
        if (i_checker.error_total() + timeout_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* muldiv_unit.f */
verilog/muldiv_pkg.sv
verilog/muldiv_if.sv
verilog/muldiv_issue.sv
verilog/muldiv_core.sv
verilog/muldiv_writeback.sv
verilog/muldiv_unit.sv
tests/muldiv_checker.sv
tests/muldiv_tb.sv

/* run_muldiv.sh */
#!/bin/sh
# Verilator build and run of the muldiv testbench

cd "$(dirname "$0")" || exit 1

LOG=muldiv_sim.log

verilator --binary --timing -Wno-fatal --top-module muldiv_tb \
    -Mdir obj_dir -o muldiv_sim -f muldiv_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/muldiv_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* tests/muldiv_testdata.txt */
// kind funct3 rd rs1 rs2 expected, all hex
// kind 0 normal under random stall, 1 flushed, 2 timed on an idle unit, ff end
2 0 01 00000007 fffffffd ffffffeb
2 4 02 ffffffec 00000003 fffffffa
0 1 03 fffffffe 00000003 ffffffff
0 2 04 ffffffff ffffffff ffffffff
0 3 05 ffffffff ffffffff fffffffe
0 0 06 12345678 00000010 23456780
0 5 07 ffffffff 00000010 0fffffff
0 6 08 ffffffec 00000003 fffffffe
0 7 09 00000064 00000007 00000002
0 4 0a 00001234 00000000 ffffffff
0 6 0b 00001234 00000000 00001234
0 4 0c 80000000 ffffffff 80000000
0 6 0d 80000000 ffffffff 00000000
0 0 00 00000003 00000004 0000000c
0 0 0e fffffffe 00000005 fffffff6
1 4 0f 00000064 00000005 00000014
0 4 10 00000064 00000005 00000014
ff 0 00 00000000 00000000 00000000
